//--- common/risk_fsm_pkg.sv
// ================================================
// risk_fsm_pkg
// state encodings for the order and cancel FSMs
// ================================================
`default_nettype none

package risk_fsm_pkg;

  typedef enum logic [1:0] {
    ord_idle,   // waiting for cpu_go
    ord_read,   // store read in flight
    ord_decide  // risk check, write, pulse
  } order_state_t;

  typedef enum logic [1:0] {
    cxl_idle,   // waiting for exchange_go
    cxl_read,   // fetch cancelled total
    cxl_write   // write back total + amount
  } cancel_state_t;

endpackage

`default_nettype wire

//--- common/risk_if.sv
// ================================================
// limit_if / cancel_if
// sequencer to RAM links for the limit store and
// the cancel store, registered one-cycle reads
// ================================================
`timescale 1ns/100ps
`default_nettype none

interface limit_if
  import risk_pkg::*;
  ();

  client_id_t rd_id;    // read address
  logic       wr_en;    // commit on this edge
  logic       wr_max;   // 1 = limit word, 0 = accumulated word
  client_id_t wr_id;    // write address
  total_t     wr_data;  // new word
  total_t     rd_accum; // accumulated total, one cycle after rd_id
  total_t     rd_max;   // limit, one cycle after rd_id

  modport ctrl  (output rd_id, wr_en, wr_max, wr_id, wr_data,
                 input  rd_accum, rd_max);
  modport store (input  rd_id, wr_en, wr_max, wr_id, wr_data,
                 output rd_accum, rd_max);

endinterface

interface cancel_if
  import risk_pkg::*;
  ();

  client_id_t  rd_id;    // read address
  logic        wr_en;    // commit on this edge
  client_id_t  wr_id;    // write address
  cancel_amt_t wr_total; // updated cancelled total
  cancel_amt_t rd_total; // cancelled total, one cycle after rd_id

  modport ctrl  (output rd_id, wr_en, wr_id, wr_total, input rd_total);
  modport store (input rd_id, wr_en, wr_id, wr_total, output rd_total);

endinterface

`default_nettype wire

//--- common/risk_pkg.sv
// ================================================
// risk_pkg
// widths, client count and vector types shared by
// the order and cancel paths of the risk gate
// ================================================
`default_nettype none

package risk_pkg;

  localparam int num_clients    = 32;                  // trading clients served
  localparam int id_width       = $clog2(num_clients); // client index bits
  localparam int amt_width      = 32;                  // order / limit amount
  localparam int cancel_width   = 16;                  // exchange cancel qty
  localparam int total_width    = 32;                  // accumulated total and limit
  localparam int exposure_width = total_width + 1;     // one spare bit for the sum

  typedef logic [id_width-1:0]       client_id_t;  // client index
  typedef logic [amt_width-1:0]      order_amt_t;  // cpu order or new limit
  typedef logic [cancel_width-1:0]   cancel_amt_t; // cancel qty, cancelled total
  typedef logic [total_width-1:0]    total_t;      // stored limit or accumulated
  typedef logic [exposure_width-1:0] exposure_t;   // accum + amt, cannot overflow

endpackage

`default_nettype wire

//--- downstream/cancel_ctrl.sv
// ================================================
// cancel_ctrl
// read-modify-write sequencer that adds exchange
// cancels to the client's cancelled total
// ================================================
`timescale 1ns/100ps
`default_nettype none

module cancel_ctrl
  import risk_pkg::*;
  import risk_fsm_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        exchange_go,
  input  client_id_t  exchange_client_id,
  input  cancel_amt_t exchange_amount,
  cancel_if.ctrl      bus
);

  cancel_state_t state;
  client_id_t    id_q;  // captured client
  cancel_amt_t   amt_q; // captured cancel qty

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= cxl_idle;
    else
      case (state)
        cxl_idle:  if (exchange_go) state <= cxl_read; // go ignored when busy
        cxl_read:  state <= cxl_write;
        cxl_write: state <= cxl_idle;
        default:   state <= cxl_idle;
      endcase
  end

  // request capture only in idle
  always_ff @(posedge clk)
  begin
    if (state == cxl_idle && exchange_go)
    begin
      id_q  <= exchange_client_id;
      amt_q <= exchange_amount;
    end
  end

  assign bus.rd_id    = id_q;                     // sampled at read edge
  assign bus.wr_id    = id_q;
  assign bus.wr_en    = (state == cxl_write);      // commit at write edge
  assign bus.wr_total = bus.rd_total + amt_q;     // wraps at 16 bits

endmodule

`default_nettype wire

//--- downstream/cancel_store.sv
// ================================================
// cancel_store
// per-client cancelled totals, valid bits for a
// sweep-free reset, sequencer and cpu read ports
// ================================================
`timescale 1ns/100ps
`default_nettype none

module cancel_store
  import risk_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  client_id_t  cpu_client_id, // cpu side read address
  output cancel_amt_t cpu_cancelled, // cpu side read data
  cancel_if.store     bus
);

  cancel_amt_t            mem [num_clients]; // cancelled totals
  logic [num_clients-1:0] valid;             // entry written since reset

  // payload array, no clear needed
  always_ff @(posedge clk)
  begin
    if (bus.wr_en)
      mem[bus.wr_id] <= bus.wr_total;
  end

  // valid bits and both registered read ports
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid         <= '0;
      bus.rd_total  <= '0;
      cpu_cancelled <= '0;
    end
    else
    begin
      if (bus.wr_en)
        valid[bus.wr_id] <= 1'b1;                   // first write arms entry
      bus.rd_total  <= valid[bus.rd_id] ? mem[bus.rd_id] : '0; // old data on collision
      cpu_cancelled <= valid[cpu_client_id] ? mem[cpu_client_id] : '0;
    end
  end

endmodule

`default_nettype wire

//--- risk_gateway.f
common/risk_pkg.sv
common/risk_fsm_pkg.sv
common/risk_if.sv
downstream/cancel_store.sv
downstream/cancel_ctrl.sv
upstream/limit_store.sv
upstream/order_ctrl.sv
source/risk_gateway.sv
sim/risk_gateway_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the risk gateway testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f risk_gateway.f \
  --top-module risk_gateway_tb -o risk_gateway_sim > build.log 2>&1 &&
./obj_dir/risk_gateway_sim > sim.log 2>&1 ||
{ echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "^sim passed$" sim.log && echo "PASS" ||
{ echo "FAIL, see sim.log"; exit 1; }

//--- sim/risk_gateway_tb.sv
// ================================================
// risk_gateway_tb
// testbench for the pre-trade risk gate with a
// per-client shadow model and reference risk check
// that compares result pulses and read ports
// ================================================
`timescale 1ns/100ps
`default_nettype none

module risk_gateway_tb;

  localparam int max_cycles = 4000; // run needs roughly 1700 cycles

  logic        clk;
  logic        reset;
  logic        cpu_go, cpu_new_max, exchange_go;
  logic [4:0]  cpu_client_id, exchange_client_id;
  logic [31:0] cpu_amount;
  logic [15:0] exchange_amount;
  logic        order_sent, order_rejected;
  logic [15:0] cancelled_orders;
  logic [31:0] accumulated_orders;

  logic [31:0] lim_sh [32];          // shadow limits
  logic [31:0] acc_sh [32];          // shadow accumulated totals
  logic [15:0] cxl_sh [32];          // shadow cancelled totals
  int          due_q [$];            // cycle at which a pulse is due
  bit          sent_q [$];           // 1 = sent expected, 0 = rejected
  logic        rd_chk, rd_chk_q;     // read check requested / staged
  logic [31:0] rd_acc_exp, rd_acc_q;
  logic [15:0] rd_cxl_exp, rd_cxl_q;
  bit          exp_sent, exp_rej;
  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  integer      seed;
  logic [4:0]  id;
  logic [1:0]  op;

  risk_gateway UUT (
    .clk (clk), .reset (reset), .cpu_go (cpu_go), .cpu_new_max (cpu_new_max),
    .exchange_go (exchange_go), .cpu_client_id (cpu_client_id),
    .exchange_client_id (exchange_client_id), .cpu_amount (cpu_amount),
    .exchange_amount (exchange_amount), .order_sent (order_sent),
    .order_rejected (order_rejected), .cancelled_orders (cancelled_orders),
    .accumulated_orders (accumulated_orders)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  // pass when accum + amount - cancelled floored at zero stays within limit
  function automatic bit order_passes(input logic [31:0] accum, input logic [31:0] amt,
                                      input logic [15:0] cxl, input logic [31:0] limit);
    longint exposure;
    exposure = longint'(accum) + longint'(amt) - longint'(cxl);
    if (exposure < 0)
      exposure = 0;
    return exposure <= longint'(limit);
  endfunction

  // one cpu request, optional second go while busy, then idle gap
  task automatic cpu_request(input logic [4:0] cid, input logic [31:0] amt,
                             input bit new_max, input bit repeat_go);
    bit pass;
    @(negedge clk);
    cpu_go        = 1'b1;
    cpu_client_id = cid;
    cpu_amount    = amt;
    cpu_new_max   = new_max;
    if (new_max)
      lim_sh[cid] = amt;
    else
    begin
      pass = order_passes(acc_sh[cid], amt, cxl_sh[cid], lim_sh[cid]);
      due_q.push_back(cycle + 3);    // pulse after edge 2
      sent_q.push_back(pass);
      if (pass)
        acc_sh[cid] = acc_sh[cid] + amt;
    end
    @(negedge clk);
    cpu_go     = repeat_go;          // lands in read state and must be dropped
    cpu_amount = amt ^ 32'h0000_0fff;
    @(negedge clk);
    cpu_go = 1'b0;
    @(negedge clk);
  endtask

  task automatic cancel_request(input logic [4:0] cid, input logic [15:0] amt,
                                input bit repeat_go);
    @(negedge clk);
    exchange_go        = 1'b1;
    exchange_client_id = cid;
    exchange_amount    = amt;
    cxl_sh[cid]        = cxl_sh[cid] + amt; // wraps at 16 bits
    @(negedge clk);
    exchange_go     = repeat_go;
    exchange_amount = amt ^ 16'h00ff;
    @(negedge clk);
    exchange_go = 1'b0;
    @(negedge clk);
  endtask

  // read ports answer one edge after the id is presented
  task automatic check_reads(input logic [4:0] cid);
    @(negedge clk);
    cpu_client_id = cid;
    rd_chk        = 1'b1;
    rd_acc_exp    = acc_sh[cid];
    rd_cxl_exp    = cxl_sh[cid];
    @(negedge clk);
    rd_chk = 1'b0;
  endtask

  always @(posedge clk)
  begin
    rd_chk_q <= rd_chk;
    rd_acc_q <= rd_acc_exp;
    rd_cxl_q <= rd_cxl_exp;
  end

  // outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (!reset)
    begin
      exp_sent = 1'b0;
      exp_rej  = 1'b0;
      if (due_q.size() > 0 && due_q[0] == cycle)
      begin
        void'(due_q.pop_front());
        exp_sent = sent_q.pop_front();
        exp_rej  = !exp_sent;
      end
      checks++;
      assert (order_sent == exp_sent) else
      begin
        errors++;
        $display("ERROR %0t order_sent expected %0b got %0b", $time, exp_sent, order_sent);
      end
      assert (order_rejected == exp_rej) else
      begin
        errors++;
        $display("ERROR %0t order_rejected expected %0b got %0b", $time, exp_rej,
                 order_rejected);
      end
      if (rd_chk_q)
      begin
        checks++;
        assert (accumulated_orders == rd_acc_q) else
        begin
          errors++;
          $display("ERROR %0t accumulated_orders expected %0d got %0d", $time, rd_acc_q,
                   accumulated_orders);
        end
        assert (cancelled_orders == rd_cxl_q) else
        begin
          errors++;
          $display("ERROR %0t cancelled_orders expected %0d got %0d", $time, rd_cxl_q,
                   cancelled_orders);
        end
      end
    end
  end

  initial
  begin
    wait (cycle >= max_cycles);
    $display("timeout: run still going after %0d cycles, %0d errors", max_cycles, errors);
    $display("sim failed");
    $finish;
  end

  initial
  begin
    seed = 32'h6abe;
    reset = 1'b1;
    cpu_go = 1'b0;
    cpu_new_max = 1'b0;
    exchange_go = 1'b0;
    cpu_client_id = '0;
    exchange_client_id = '0;
    cpu_amount = '0;
    exchange_amount = '0;
    rd_chk = 1'b0;
    rd_acc_exp = '0;
    rd_cxl_exp = '0;
    lim_sh = '{default: '0};
    acc_sh = '{default: '0};
    cxl_sh = '{default: '0};
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < 32; i++)          // all clients read zero after reset
      check_reads(5'(i));
    cpu_request(5'd3, 32'd100, 1'b0, 1'b0); // zero limit so rejected
    cpu_request(5'd17, 32'd1, 1'b0, 1'b0);

    cpu_request(5'd5, 32'd1000, 1'b1, 1'b0);
    check_reads(5'd5);
    repeat (4)
    begin
      cpu_request(5'd5, 32'd300, 1'b0, 1'b0); // fourth one overruns
      check_reads(5'd5);
    end

    cancel_request(5'd5, 16'd150, 1'b0);
    cpu_request(5'd5, 32'd300, 1'b0, 1'b0); // 1050 > 1000
    cancel_request(5'd5, 16'd100, 1'b0);
    cpu_request(5'd5, 32'd300, 1'b0, 1'b0); // 950 now fits
    check_reads(5'd5);
    cpu_request(5'd7, 32'd10, 1'b1, 1'b0);
    cancel_request(5'd7, 16'd5000, 1'b0);
    cpu_request(5'd7, 32'd200, 1'b0, 1'b0); // clamps at zero
    check_reads(5'd7);
    repeat (6)
    begin
      cancel_request(5'd9, 16'($random(seed)) | 16'h8000, 1'b0); // forces wraps
      check_reads(5'd9);
    end

    repeat (250)                           // mixed traffic
    begin
      id = 5'($random(seed));
      op = 2'($random(seed));
      case (op)
        2'd0: cpu_request(id, $random(seed) & 32'h000f_ffff, 1'b1, 1'b0);
        2'd3: cancel_request(id, 16'($random(seed)), 1'b0);
        default: cpu_request(id, $random(seed) & 32'h0001_ffff, 1'b0, 1'b0);
      endcase
      check_reads(id);
    end

    cpu_request(5'd5, 32'd50, 1'b0, 1'b1);  // second go dropped
    check_reads(5'd5);
    cancel_request(5'd5, 16'd40, 1'b1);
    check_reads(5'd5);

    repeat (4) @(negedge clk);
    $display("run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/risk_gateway.sv
// ================================================
// risk_gateway
// pre-trade risk gate top: order path with limit
// store, cancel path with cancel store
// ================================================
`timescale 1ns/100ps
`default_nettype none

module risk_gateway
(
  input  logic        clk,
  input  logic        reset,
  input  logic        cpu_go,
  input  logic        cpu_new_max,
  input  logic        exchange_go,
  input  logic [4:0]  cpu_client_id,
  input  logic [4:0]  exchange_client_id,
  input  logic [31:0] cpu_amount,
  input  logic [15:0] exchange_amount,
  output logic        order_sent,
  output logic        order_rejected,
  output logic [15:0] cancelled_orders,
  output logic [31:0] accumulated_orders
);

  limit_if     lim_bus ();  // order_ctrl <-> limit_store
  cancel_if    cxl_bus ();  // cancel_ctrl <-> cancel_store
  logic [15:0] cpu_cancelled; // cancelled total for the order's client

  // cpu read port follows the order sequencer's read address
  cancel_store u_cancel_store (
    .clk           (clk),
    .reset         (reset),
    .cpu_client_id (lim_bus.rd_id),
    .cpu_cancelled (cpu_cancelled),
    .bus           (cxl_bus.store)
  );

  cancel_ctrl u_cancel_ctrl (
    .clk                (clk),
    .reset              (reset),
    .exchange_go        (exchange_go),
    .exchange_client_id (exchange_client_id),
    .exchange_amount    (exchange_amount),
    .bus                (cxl_bus.ctrl)
  );

  limit_store u_limit_store (
    .clk   (clk),
    .reset (reset),
    .bus   (lim_bus.store)
  );

  order_ctrl u_order_ctrl (
    .clk            (clk),
    .reset          (reset),
    .cpu_go         (cpu_go),
    .cpu_new_max    (cpu_new_max),
    .cpu_client_id  (cpu_client_id),
    .cpu_amount     (cpu_amount),
    .cpu_cancelled  (cpu_cancelled),
    .order_sent     (order_sent),
    .order_rejected (order_rejected),
    .bus            (lim_bus.ctrl)
  );

  assign cancelled_orders   = cpu_cancelled;    // one cycle behind cpu_client_id
  assign accumulated_orders = lim_bus.rd_accum; // same read timing

endmodule

`default_nettype wire

//--- upstream/limit_store.sv
// ================================================
// limit_store
// per-client limit and accumulated-total RAM with
// valid bits, one registered read of both words
// ================================================
`timescale 1ns/100ps
`default_nettype none

module limit_store
  import risk_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  limit_if.store  bus
);

  total_t                 max_mem   [num_clients]; // limit words
  total_t                 accum_mem [num_clients]; // accumulated words
  logic [num_clients-1:0] max_valid;               // limit set since reset
  logic [num_clients-1:0] accum_valid;             // accum written since reset

  // payload arrays, wr_max steers the write
  always_ff @(posedge clk)
  begin
    if (bus.wr_en)
    begin
      if (bus.wr_max)
        max_mem[bus.wr_id] <= bus.wr_data;
      else
        accum_mem[bus.wr_id] <= bus.wr_data;
    end
  end

  // valid tracking
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      max_valid   <= '0;
      accum_valid <= '0;
    end
    else if (bus.wr_en)
    begin
      if (bus.wr_max)
        max_valid[bus.wr_id] <= 1'b1;
      else
        accum_valid[bus.wr_id] <= 1'b1;
    end
  end

  // registered read, invalid entries read zero
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bus.rd_max   <= '0;
      bus.rd_accum <= '0;
    end
    else
    begin
      bus.rd_max   <= max_valid[bus.rd_id]   ? max_mem[bus.rd_id]   : '0;
      bus.rd_accum <= accum_valid[bus.rd_id] ? accum_mem[bus.rd_id] : '0;
    end
  end

endmodule

`default_nettype wire

//--- upstream/order_ctrl.sv
// ================================================
// order_ctrl
// cpu order / limit sequencer, exposure check
// against the stored limit, sent/rejected pulses
// ================================================
`timescale 1ns/100ps
`default_nettype none

module order_ctrl
  import risk_pkg::*;
  import risk_fsm_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        cpu_go,
  input  logic        cpu_new_max,
  input  client_id_t  cpu_client_id,
  input  order_amt_t  cpu_amount,
  input  cancel_amt_t cpu_cancelled, // registered alongside rd_accum
  output logic        order_sent,
  output logic        order_rejected,
  limit_if.ctrl       bus
);

  order_state_t state;
  client_id_t   id_q;      // captured client
  order_amt_t   amount_q;  // captured amount or new limit
  logic         new_max_q; // limit update, no risk check
  exposure_t    gross;     // accum + amount
  exposure_t    exposure;  // gross - cancelled, floor at zero
  logic         pass;      // exposure within limit

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ord_idle;
    else
      case (state)
        ord_idle:   if (cpu_go) state <= ord_read; // busy drops further gos
        ord_read:   state <= ord_decide;
        ord_decide: state <= ord_idle;
        default:    state <= ord_idle;
      endcase
  end

  // request capture
  always_ff @(posedge clk)
  begin
    if (state == ord_idle && cpu_go)
    begin
      id_q      <= cpu_client_id;
      amount_q  <= cpu_amount;
      new_max_q <= cpu_new_max;
    end
  end

  // exposure check on the words read at edge 1
  always_comb
  begin
    gross = exposure_t'(bus.rd_accum) + exposure_t'(amount_q);
    if (gross > exposure_t'(cpu_cancelled))
      exposure = gross - exposure_t'(cpu_cancelled);
    else
      exposure = '0;                                // more cancelled than traded
    pass = (exposure <= exposure_t'(bus.rd_max));
  end

  // result pulses land on edge 2
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      order_sent     <= 1'b0;
      order_rejected <= 1'b0;
    end
    else
    begin
      order_sent     <= (state == ord_decide) && !new_max_q && pass;
      order_rejected <= (state == ord_decide) && !new_max_q && !pass;
    end
  end

  // idle tracks the cpu id so the top outputs follow it
  assign bus.rd_id   = (state == ord_idle) ? cpu_client_id : id_q;
  assign bus.wr_id   = id_q;
  assign bus.wr_max  = new_max_q;
  assign bus.wr_en   = (state == ord_decide) && (new_max_q || pass);
  assign bus.wr_data = new_max_q ? amount_q : bus.rd_accum + amount_q; // 32-bit accum

endmodule

`default_nettype wire
